// ==== dv/burst_mover_checker.sv ====
`timescale 1ns/10ps

module burst_mover_checker (
	input logic ti_clk,
	input logic reset,
	input logic pop,
	input logic empty,
	input logic push,
	input logic [5:0] out_count,
	input logic wr_en,
	input logic rd_en
);

	// Input FIFO is only popped while it holds an entry
	pop_not_empty: assert property (@(posedge ti_clk) disable iff (reset)
		!(pop && empty))
		else $error("pop while the input FIFO is empty");

	// Output FIFO never takes a push when it is full
	push_not_full: assert property (@(posedge ti_clk) disable iff (reset)
		!(push && (out_count == 6'(stream_fifo_pkg::out_depth))))
		else $error("push while the output FIFO is full");

	// Buffer memory sees one direction at a time
	one_direction: assert property (@(posedge ti_clk) disable iff (reset)
		!(wr_en && rd_en))
		else $error("buffer write and read in the same cycle");

endmodule

bind burst_mover burst_mover_checker i_burst_mover_checker (
	.ti_clk(ti_clk),
	.reset(reset),
	.pop(pop),
	.empty(empty),
	.push(push),
	.out_count(out_count),
	.wr_en(port.wr_en),
	.rd_en(port.rd_en)
);

// ==== dv/stream_fifo_tb.sv ====
`timescale 1ns/10ps

module stream_fifo_tb;

	localparam int unsigned seed = 32'hecee;
	localparam int rounds = 12;
	localparam int quiet_cycles = 40;
	localparam int timeout_cycles = 2000;

	logic ti_clk;
	logic reset;
	logic write_to;
	logic [15:0] data_in;
	logic read_from;
	logic [31:0] data_out;
	logic [31:0] num_words;

	// Reference model: pair words in order, plus the count in 16-bit words
	logic [31:0] pair_q [$];
	logic [15:0] pending_half;
	logic have_half;
	int model_words;
	logic [31:0] last_word;

	int errors;
	int timeouts;

	tb_clock_gen i_tb_clock_gen (
		.ti_clk(ti_clk),
		.reset(reset)
	);

	stream_fifo_top i_stream_fifo_top (
		.ti_clk(ti_clk),
		.reset(reset),
		.write_to(write_to),
		.data_in(data_in),
		.read_from(read_from),
		.data_out(data_out),
		.num_words(num_words)
	);

	task automatic step();
		@(posedge ti_clk);
		#1;
	endtask

	task automatic end_run();
		$display("Run finished with %0d errors and %0d timeouts", errors, timeouts);
		if (errors == 0 && timeouts == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	endtask

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (actual !== expected) begin
			$display("Fail %s expected 0x%0h actual 0x%0h", name, expected, actual);
			errors++;
		end
	endtask

	task automatic write_sample(input logic [15:0] sample);
		write_to = 1'b1;
		data_in = sample;
		step();
		write_to = 1'b0;
		// Earlier sample goes in the low half
		if (have_half)
			pair_q.push_back({sample, pending_half});
		else
			pending_half = sample;
		have_half = !have_half;
		model_words++;
	endtask

	// Quiet means num_words unchanged for quiet_cycles in a row
	task automatic wait_quiet();
		logic [31:0] prev;
		int stable;
		int guard;
		prev = num_words;
		stable = 0;
		guard = 0;
		while (stable < quiet_cycles && guard < timeout_cycles) begin
			step();
			guard++;
			if (num_words == prev)
				stable++;
			else
				stable = 0;
			prev = num_words;
		end
		if (stable < quiet_cycles) begin
			$display("Timeout, num_words did not settle within %0d cycles", timeout_cycles);
			timeouts++;
			end_run();
		end
	endtask

	task automatic read_word(input string name);
		logic [31:0] expected;
		read_from = 1'b1;
		step();
		read_from = 1'b0;
		expected = pair_q.pop_front();
		model_words -= 2;
		last_word = expected;
		check_value(name, expected, data_out);
	endtask

	// Reads every whole burst the output FIFO can hold
	task automatic read_bursts(input string name);
		int k;
		wait_quiet();
		k = (pair_q.size() / stream_fifo_pkg::burst_len) * stream_fifo_pkg::burst_len;
		if (k > stream_fifo_pkg::out_depth)
			k = stream_fifo_pkg::out_depth;
		repeat (k) read_word(name);
		wait_quiet();
		check_value({name, "_fill"}, 32'(model_words), num_words);
	endtask

	task automatic drain_all();
		int passes;
		passes = 0;
		while (pair_q.size() >= stream_fifo_pkg::burst_len && passes < 64) begin
			read_bursts("drain_data");
			passes++;
		end
		if (pair_q.size() >= stream_fifo_pkg::burst_len) begin
			$display("Timeout, the output side did not drain");
			timeouts++;
			end_run();
		end
	endtask

	initial begin
		int guard;
		int n;
		int gap;
		write_to = 1'b0;
		data_in = '0;
		read_from = 1'b0;
		have_half = 1'b0;
		pending_half = '0;
		model_words = 0;
		last_word = '0;
		errors = 0;
		timeouts = 0;
		void'($urandom(seed));

		// Reset is looked at on the clock edge, where it is stable
		guard = 0;
		@(posedge ti_clk);
		while (reset && guard < 100) begin
			@(posedge ti_clk);
			guard++;
		end
		#1;
		if (reset) begin
			$display("Timeout, reset was never released");
			timeouts++;
			end_run();
		end
		check_value("reset_num_words", '0, num_words);
		check_value("reset_data_out", '0, data_out);

		////////////////////////////////////////
		// Random write bursts with random reads
		////////////////////////////////////////
		for (int r = 0; r < rounds; r++) begin
			// At most 24 samples a round, so the total stays far below buf_depth*2
			n = $urandom_range(24, 1);
			for (int i = 0; i < n; i++) begin
				write_sample(16'($urandom));
				gap = $urandom_range(3, 0);
				repeat (gap) step();
			end
			wait_quiet();
			check_value("fill_count", 32'(model_words), num_words);
			if ($urandom_range(1, 0) == 1)
				read_bursts("read_data");
		end

		////////////////////////////////////////
		// Leftover samples short of a burst
		////////////////////////////////////////
		drain_all();
		n = 5;
		if ((model_words + n) % (2 * stream_fifo_pkg::burst_len) == 0)
			n = 7;
		repeat (n) write_sample(16'($urandom));
		wait_quiet();
		check_value("leftover_fill", 32'(model_words), num_words);
		// Complete the burst, then the leftovers must come out in order
		n = (2 * stream_fifo_pkg::burst_len) - (model_words % (2 * stream_fifo_pkg::burst_len));
		repeat (n) write_sample(16'($urandom));
		drain_all();
		check_value("drained_fill", 32'(model_words), num_words);

		// Underflow, the output register keeps the last word
		read_from = 1'b1;
		step();
		read_from = 1'b0;
		check_value("underflow_data", last_word, data_out);
		wait_quiet();
		check_value("underflow_fill", 32'(model_words), num_words);

		end_run();
	end

endmodule

// ==== dv/tb_clock_gen.sv ====
`timescale 1ns/10ps

module tb_clock_gen (
	output logic ti_clk,
	output logic reset
);

	localparam real half_period = 4.0;

	initial begin
		ti_clk = 1'b0;
		forever #(half_period) ti_clk = ~ti_clk;
	end

	// Reset held for two rising edges, released just after the second
	initial begin
		reset = 1'b1;
		repeat (2) @(posedge ti_clk);
		#1;
		reset = 1'b0;
	end

endmodule

// ==== rtl/buffer_port_if.sv ====
`timescale 1ns/10ps

interface buffer_port_if;

	// Write side, data lands in the array on the cycle wr_en is high
	logic wr_en;
	logic [stream_fifo_pkg::buf_addr_width-1:0] wr_addr;
	stream_fifo_pkg::pair_entry_t wr_data;

	// Read side, rd_data follows rd_en by one cycle
	logic rd_en;
	logic [stream_fifo_pkg::buf_addr_width-1:0] rd_addr;
	stream_fifo_pkg::pair_entry_t rd_data;

	modport mover (
		output wr_en,
		output wr_addr,
		output wr_data,
		output rd_en,
		output rd_addr,
		input rd_data
	);

	modport ram (
		input wr_en,
		input wr_addr,
		input wr_data,
		input rd_en,
		input rd_addr,
		output rd_data
	);

endinterface

// ==== rtl/buffer_ram.sv ====
`timescale 1ns/10ps

module buffer_ram (
	input logic ti_clk,
	buffer_port_if.ram port
);

	// Stand-in for the external SDRAM
	stream_fifo_pkg::pair_entry_t mem [stream_fifo_pkg::buf_depth];

	////////////////////////////////////////
	// Write port
	////////////////////////////////////////
	always_ff @(posedge ti_clk) begin
		if (port.wr_en)
			mem[port.wr_addr] <= port.wr_data;
	end

	////////////////////////////////////////
	// Read port, one cycle of latency
	////////////////////////////////////////
	always_ff @(posedge ti_clk) begin
		if (port.rd_en)
			port.rd_data <= mem[port.rd_addr];
	end

endmodule

// ==== rtl/burst_mover.sv ====
`timescale 1ns/10ps

module burst_mover (
	input logic ti_clk,
	input logic reset,
	output logic pop,
	input stream_fifo_pkg::pair_entry_t entry,
	input logic empty,
	input logic [6:0] entry_count,
	buffer_port_if.mover port,
	output logic push,
	output logic [31:0] push_data,
	input logic [5:0] out_count,
	output logic [7:0] wr_ptr,
	output logic [7:0] rd_ptr
);

	logic [1:0] state;
	logic [stream_fifo_pkg::beat_width-1:0] beat;
	logic [stream_fifo_pkg::buf_addr_width-1:0] distance;
	logic write_ready;
	logic read_ready;
	logic wr_beat;
	logic rd_pending;

	// Entries held in memory, wraps like the pointers do
	assign distance = wr_ptr - rd_ptr;

	assign write_ready = (entry_count >= stream_fifo_pkg::in_burst_min);
	assign read_ready = (distance >= stream_fifo_pkg::buf_burst_min) &&
		(out_count <= stream_fifo_pkg::out_room_max);

	////////////////////////////////////////
	// Memory side
	////////////////////////////////////////
	// One entry leaves the input FIFO on every write beat
	assign wr_beat = (state == stream_fifo_pkg::mover_write);

	assign pop = wr_beat;
	assign port.wr_en = wr_beat;
	assign port.wr_addr = wr_ptr;
	assign port.wr_data = entry;

	// Reads go out on the first burst_len beats; the last beat only collects data
	assign port.rd_en = (state == stream_fifo_pkg::mover_read) &&
		(beat != stream_fifo_pkg::last_read_beat);
	assign port.rd_addr = rd_ptr;

	// Data returns one cycle after each read
	assign push = rd_pending;
	assign push_data = port.rd_data.word;

	////////////////////////////////////////
	// Burst FSM and pointers
	////////////////////////////////////////
	always_ff @(posedge ti_clk) begin
		if (reset) begin
			state <= stream_fifo_pkg::mover_idle;
			beat <= '0;
			wr_ptr <= '0;
			rd_ptr <= '0;
			rd_pending <= 1'b0;
		end else begin
			rd_pending <= port.rd_en;
			if (wr_beat)
				wr_ptr <= wr_ptr + 1'b1;
			if (port.rd_en)
				rd_ptr <= rd_ptr + 1'b1;

			case (state)
				stream_fifo_pkg::mover_idle: begin
					beat <= '0;
					// Writes win when both directions are eligible
					if (write_ready)
						state <= stream_fifo_pkg::mover_write;
					else if (read_ready)
						state <= stream_fifo_pkg::mover_read;
				end
				stream_fifo_pkg::mover_write: begin
					if (beat == stream_fifo_pkg::last_write_beat) begin
						state <= stream_fifo_pkg::mover_idle;
						beat <= '0;
					end else begin
						beat <= beat + 1'b1;
					end
				end
				stream_fifo_pkg::mover_read: begin
					if (beat == stream_fifo_pkg::last_read_beat) begin
						state <= stream_fifo_pkg::mover_idle;
						beat <= '0;
					end else begin
						beat <= beat + 1'b1;
					end
				end
				default: begin
					state <= stream_fifo_pkg::mover_idle;
					beat <= '0;
				end
			endcase
		end
	end

endmodule

// ==== rtl/fill_monitor.sv ====
`timescale 1ns/10ps

module fill_monitor (
	input logic ti_clk,
	input logic reset,
	input logic [7:0] wr_ptr,
	input logic [7:0] rd_ptr,
	input logic [7:0] half_count,
	input logic [5:0] out_count,
	output logic [31:0] num_words
);

	logic [stream_fifo_pkg::buf_addr_width-1:0] distance;
	logic [31:0] buf_words;
	logic [31:0] out_words;

	// Entries between the pointers, wrapped at buf_depth
	assign distance = wr_ptr - rd_ptr;

	// Each entry in memory or in the output FIFO is two samples
	assign buf_words = 32'({distance, 1'b0});
	assign out_words = 32'({out_count, 1'b0});

	always_ff @(posedge ti_clk) begin
		if (reset)
			num_words <= '0;
		else
			num_words <= buf_words + 32'(half_count) + out_words;
	end

endmodule

// ==== rtl/input_pair_fifo.sv ====
`timescale 1ns/10ps

module input_pair_fifo (
	input logic ti_clk,
	input logic reset,
	input logic write_to,
	input logic [15:0] data_in,
	input logic pop,
	output stream_fifo_pkg::pair_entry_t entry,
	output logic empty,
	output logic [6:0] entry_count,
	output logic [7:0] half_count
);

	stream_fifo_pkg::pair_entry_t store [stream_fifo_pkg::in_depth];
	stream_fifo_pkg::pair_entry_t new_entry;

	logic [stream_fifo_pkg::sample_width-1:0] half_reg;
	logic half_valid;
	logic commit;
	logic [stream_fifo_pkg::in_addr_width-1:0] wr_idx;
	logic [stream_fifo_pkg::in_addr_width-1:0] rd_idx;

	// Second sample of a pair completes an entry
	assign commit = write_to & half_valid;

	always_comb begin
		new_entry.half[0] = half_reg;
		new_entry.half[1] = data_in;
	end

	////////////////////////////////////////
	// Pair register and entry store
	////////////////////////////////////////
	always_ff @(posedge ti_clk) begin
		if (write_to && !half_valid)
			half_reg <= data_in;
		if (commit)
			store[wr_idx] <= new_entry;
	end

	always_ff @(posedge ti_clk) begin
		if (reset) begin
			half_valid <= 1'b0;
			wr_idx <= '0;
			rd_idx <= '0;
			entry_count <= '0;
		end else begin
			if (write_to)
				half_valid <= ~half_valid;
			if (commit)
				wr_idx <= wr_idx + 1'b1;
			if (pop)
				rd_idx <= rd_idx + 1'b1;
			if (commit && !pop)
				entry_count <= entry_count + 1'b1;
			else if (!commit && pop)
				entry_count <= entry_count - 1'b1;
		end
	end

	// Show-ahead, the oldest entry is always on the output
	assign entry = store[rd_idx];
	assign empty = (entry_count == '0);

	// Two halves per stored entry plus the one waiting for its partner
	assign half_count = {entry_count, half_valid};

endmodule

// ==== rtl/output_fifo.sv ====
`timescale 1ns/10ps

module output_fifo (
	input logic ti_clk,
	input logic reset,
	input logic push,
	input logic [31:0] push_data,
	input logic read_from,
	output logic [31:0] data_out,
	output logic [5:0] count
);

	logic [stream_fifo_pkg::word_width-1:0] store [stream_fifo_pkg::out_depth];
	logic [stream_fifo_pkg::out_addr_width-1:0] wr_idx;
	logic [stream_fifo_pkg::out_addr_width-1:0] rd_idx;
	logic do_read;

	// A read of an empty FIFO does nothing, so the last word stays on data_out
	assign do_read = read_from && (count != '0);

	always_ff @(posedge ti_clk) begin
		if (push)
			store[wr_idx] <= push_data;
	end

	////////////////////////////////////////
	// Pointers, count and read register
	////////////////////////////////////////
	always_ff @(posedge ti_clk) begin
		if (reset) begin
			wr_idx <= '0;
			rd_idx <= '0;
			count <= '0;
			data_out <= '0;
		end else begin
			if (push)
				wr_idx <= wr_idx + 1'b1;
			if (do_read) begin
				data_out <= store[rd_idx];
				rd_idx <= rd_idx + 1'b1;
			end
			if (push && !do_read)
				count <= count + 1'b1;
			else if (!push && do_read)
				count <= count - 1'b1;
		end
	end

endmodule

// ==== rtl/stream_fifo_pkg.sv ====
package stream_fifo_pkg;

	////////////////////////////////////////
	// Data widths and depths
	////////////////////////////////////////
	localparam int sample_width = 16;
	localparam int word_width = 32;
	localparam int burst_len = 4;
	localparam int in_depth = 64;
	localparam int out_depth = 32;
	localparam int buf_depth = 256;

	// Pointer and counter widths
	localparam int in_addr_width = 6;
	localparam int out_addr_width = 5;
	localparam int buf_addr_width = 8;
	localparam int beat_width = 3;

	////////////////////////////////////////
	// Burst mover constants
	////////////////////////////////////////
	localparam logic [1:0] mover_idle = 2'd0;
	localparam logic [1:0] mover_write = 2'd1;
	localparam logic [1:0] mover_read = 2'd2;

	localparam logic [beat_width-1:0] last_write_beat = beat_width'(burst_len - 1);
	localparam logic [beat_width-1:0] last_read_beat = beat_width'(burst_len);
	localparam logic [in_addr_width:0] in_burst_min = (in_addr_width + 1)'(burst_len);
	localparam logic [buf_addr_width-1:0] buf_burst_min = buf_addr_width'(burst_len);
	// Output count at or below this leaves room for one burst
	localparam logic [out_addr_width:0] out_room_max = (out_addr_width + 1)'(out_depth - burst_len);

	// One 32-bit entry, seen whole or as two samples; half 0 is the earlier one
	typedef union packed {
		logic [word_width-1:0] word;
		logic [1:0][sample_width-1:0] half;
	} pair_entry_t;

endpackage

// ==== rtl/stream_fifo_top.sv ====
`timescale 1ns/10ps

module stream_fifo_top (
	input logic ti_clk,
	input logic reset,
	input logic write_to,
	input logic [15:0] data_in,
	input logic read_from,
	output logic [31:0] data_out,
	output logic [31:0] num_words
);

	// Input FIFO to mover
	logic pop;
	stream_fifo_pkg::pair_entry_t entry;
	logic empty;
	logic [6:0] entry_count;
	logic [7:0] half_count;

	// Mover to output FIFO
	logic push;
	logic [31:0] push_data;
	logic [5:0] out_count;

	// Buffer pointers for the fill count
	logic [7:0] wr_ptr;
	logic [7:0] rd_ptr;

	buffer_port_if i_buffer_port ();

	input_pair_fifo i_input_pair_fifo (
		.ti_clk(ti_clk),
		.reset(reset),
		.write_to(write_to),
		.data_in(data_in),
		.pop(pop),
		.entry(entry),
		.empty(empty),
		.entry_count(entry_count),
		.half_count(half_count)
	);

	burst_mover i_burst_mover (
		.ti_clk(ti_clk),
		.reset(reset),
		.pop(pop),
		.entry(entry),
		.empty(empty),
		.entry_count(entry_count),
		.port(i_buffer_port.mover),
		.push(push),
		.push_data(push_data),
		.out_count(out_count),
		.wr_ptr(wr_ptr),
		.rd_ptr(rd_ptr)
	);

	buffer_ram i_buffer_ram (
		.ti_clk(ti_clk),
		.port(i_buffer_port.ram)
	);

	output_fifo i_output_fifo (
		.ti_clk(ti_clk),
		.reset(reset),
		.push(push),
		.push_data(push_data),
		.read_from(read_from),
		.data_out(data_out),
		.count(out_count)
	);

	fill_monitor i_fill_monitor (
		.ti_clk(ti_clk),
		.reset(reset),
		.wr_ptr(wr_ptr),
		.rd_ptr(rd_ptr),
		.half_count(half_count),
		.out_count(out_count),
		.num_words(num_words)
	);

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
# Builds the stream FIFO testbench with Verilator and runs it

set -u

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
sim_bin=stream_fifo_sim
log_file=sim.log

verilator --binary --timing --assert -f sim.f --top-module stream_fifo_tb \
	--Mdir "$build_dir" -o "$sim_bin"
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

"./$build_dir/$sim_bin" > "$log_file" 2>&1
sim_status=$?
cat "$log_file"
if [ $sim_status -ne 0 ]; then
	echo "Simulation exited with status $sim_status"
	exit 1
fi

if grep -q "test failed" "$log_file"; then
	exit 1
fi
exit 0

// ==== sim.f ====
rtl/stream_fifo_pkg.sv
rtl/buffer_port_if.sv
rtl/input_pair_fifo.sv
rtl/buffer_ram.sv
rtl/burst_mover.sv
rtl/output_fifo.sv
rtl/fill_monitor.sv
rtl/stream_fifo_top.sv
dv/tb_clock_gen.sv
dv/burst_mover_checker.sv
dv/stream_fifo_tb.sv
